// File: hw/ddr4_tg_pkg.sv
// Sizes fixed here; the window must fit in APP_ADDR_W bits and the pattern needs APP_DATA_W = 2*SEED_W
package ddr4_tg_pkg;

  // ********************
  // Sizes
  // ********************
  localparam int APP_ADDR_W = 8;
  localparam int APP_DATA_W = 64;
  localparam int SEED_W     = 32;
  localparam int ERR_CNT_W  = 9;
  // Scratch memory covers the full address space
  localparam int MEM_WORDS  = 1 << APP_ADDR_W;
  // Cycles from read command to read response
  localparam int RD_LATENCY = 2;

  // ********************
  // Vector types
  // ********************
  typedef logic [APP_ADDR_W-1:0] app_addr_t;
  typedef logic [APP_DATA_W-1:0] app_data_t;
  typedef logic [ERR_CNT_W-1:0]  err_cnt_t;
  typedef logic [SEED_W-1:0]     seed_t;

  // Application side command, one per valid cycle
  typedef struct packed {
    logic      wr_en;
    logic      rd_en;
    logic      last;
    app_addr_t addr;
    app_data_t data;
  } app_cmd_t;

  // Read response with its address tag
  typedef struct packed {
    app_addr_t addr;
    app_data_t data;
    logic      last;
  } rd_rsp_t;

  // Generator phases
  typedef enum logic [1:0] {
    TG_IDLE  = 2'd0,
    TG_WRITE = 2'd1,
    TG_READ  = 2'd2
  } tg_state_e;

  // ********************
  // Data pattern
  // ********************
  // Upper half is seed XOR address, lower half its inverse
  function automatic app_data_t tg_pattern(app_addr_t addr, seed_t seed);
    seed_t hi;
    hi = seed ^ SEED_W'(addr);
    return {hi, ~hi};
  endfunction

endpackage

// File: hw/tg_cmd_gen.sv
// Run settings are sampled on an accepted start; start_i is ignored while busy_o is high
`timescale 1ns/1ns

module tg_cmd_gen (
  input  logic                   c0_ddr4_clk,
  input  logic                   arst_n_i,
  input  logic                   init_calib_complete_i,
  input  logic                   start_i,
  input  ddr4_tg_pkg::seed_t     seed_i,
  input  ddr4_tg_pkg::app_addr_t len_i,
  input  logic                   inject_en_i,
  input  ddr4_tg_pkg::app_addr_t inject_addr_i,
  output logic                   cmd_valid_o,
  output ddr4_tg_pkg::app_cmd_t  cmd_o,
  output logic                   start_pulse_o,
  output ddr4_tg_pkg::seed_t     seed_o,
  output logic                   busy_o
);
  import ddr4_tg_pkg::*;

  tg_state_e state_q;
  app_addr_t addr_q;
  logic      busy_q;
  logic [1:0] drain_q;
  logic      start_pulse_q;

  // Run settings
  seed_t     seed_q;
  app_addr_t len_q;
  logic      inj_en_q;
  app_addr_t inj_addr_q;

  logic accept;
  logic last_addr;
  logic inj_hit;

  // Start only from a quiet generator with a calibrated memory
  assign accept    = start_i && init_calib_complete_i && (state_q == TG_IDLE) && !busy_q;
  assign last_addr = (addr_q == len_q);
  assign inj_hit   = inj_en_q && (state_q == TG_WRITE) && (addr_q == inj_addr_q);

  // ********************
  // Settings capture
  // ********************
  always_ff @(posedge c0_ddr4_clk) begin
    if (accept) begin
      seed_q     <= seed_i;
      len_q      <= len_i;
      inj_en_q   <= inject_en_i;
      inj_addr_q <= inject_addr_i;
    end
  end

  // ********************
  // Phase control
  // ********************
  always_ff @(posedge c0_ddr4_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q       <= TG_IDLE;
      addr_q        <= '0;
      busy_q        <= 1'b0;
      drain_q       <= '0;
      start_pulse_q <= 1'b0;
    end else begin
      start_pulse_q <= accept;
      case (state_q)
        TG_IDLE: begin
          if (accept) begin
            state_q <= TG_WRITE;
            addr_q  <= '0;
            busy_q  <= 1'b1;
          end else if (drain_q != '0) begin
            // Wait for the last response to reach the checker
            drain_q <= drain_q - 2'd1;
          end else begin
            busy_q <= 1'b0;
          end
        end
        TG_WRITE: begin
          if (last_addr) begin
            state_q <= TG_READ;
            addr_q  <= '0;
          end else begin
            addr_q <= addr_q + 1'b1;
          end
        end
        TG_READ: begin
          if (last_addr) begin
            state_q <= TG_IDLE;
            addr_q  <= '0;
            // Read latency plus the checker register
            drain_q <= 2'(RD_LATENCY);
          end else begin
            addr_q <= addr_q + 1'b1;
          end
        end
        default: begin
          state_q <= TG_IDLE;
        end
      endcase
    end
  end

  // ********************
  // Command output
  // ********************
  assign cmd_valid_o = (state_q != TG_IDLE);

  always_comb begin
    cmd_o.wr_en = (state_q == TG_WRITE);
    cmd_o.rd_en = (state_q == TG_READ);
    cmd_o.last  = (state_q == TG_READ) && last_addr;
    cmd_o.addr  = addr_q;
    // Fault insertion flips bit 0 of one written word
    cmd_o.data  = tg_pattern(addr_q, seed_q) ^ APP_DATA_W'(inj_hit);
  end

  assign start_pulse_o = start_pulse_q;
  assign seed_o        = seed_q;
  assign busy_o        = busy_q;

endmodule

// File: hw/tg_mem_buffer.sv
// Scratch memory has no reset; reading an unwritten word returns undefined data
`timescale 1ns/1ns

module tg_mem_buffer (
  input  logic                  c0_ddr4_clk,
  input  logic                  arst_n_i,
  input  logic                  cmd_valid_i,
  input  ddr4_tg_pkg::app_cmd_t cmd_i,
  output logic                  rsp_valid_o,
  output ddr4_tg_pkg::rd_rsp_t  rsp_o
);
  import ddr4_tg_pkg::*;

  app_data_t mem [MEM_WORDS];

  // Read pipeline, stage 0 holds the memory output
  logic [RD_LATENCY-1:0] vld_q;
  rd_rsp_t               pipe_q [RD_LATENCY];

  logic wr_req;
  logic rd_req;

  assign wr_req = cmd_valid_i && cmd_i.wr_en;
  assign rd_req = cmd_valid_i && cmd_i.rd_en;

  // ********************
  // Storage
  // ********************
  always_ff @(posedge c0_ddr4_clk) begin
    if (wr_req) begin
      mem[cmd_i.addr] <= cmd_i.data;
    end
  end

  // Valid bits travel with the data
  always_ff @(posedge c0_ddr4_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[RD_LATENCY-2:0], rd_req};
    end
  end

  // Tag, data and last flag
  always_ff @(posedge c0_ddr4_clk) begin
    pipe_q[0].addr <= cmd_i.addr;
    pipe_q[0].data <= mem[cmd_i.addr];
    pipe_q[0].last <= cmd_i.last;
    for (int i = 1; i < RD_LATENCY; i++) begin
      pipe_q[i] <= pipe_q[i-1];
    end
  end

  assign rsp_valid_o = vld_q[RD_LATENCY-1];
  assign rsp_o       = pipe_q[RD_LATENCY-1];

endmodule

// File: hw/tg_rd_checker.sv
// Seed must stay stable while responses arrive; results clear only on start_pulse_i
`timescale 1ns/1ns

module tg_rd_checker (
  input  logic                   c0_ddr4_clk,
  input  logic                   arst_n_i,
  input  logic                   start_pulse_i,
  input  ddr4_tg_pkg::seed_t     seed_i,
  input  logic                   rsp_valid_i,
  input  ddr4_tg_pkg::rd_rsp_t   rsp_i,
  output logic                   done_o,
  output logic                   compare_error_o,
  output ddr4_tg_pkg::err_cnt_t  err_count_o,
  output ddr4_tg_pkg::app_addr_t first_err_addr_o
);
  import ddr4_tg_pkg::*;

  app_data_t expected;
  logic      mismatch;

  logic      done_q;
  logic      err_flag_q;
  err_cnt_t  err_cnt_q;
  app_addr_t first_addr_q;

  // ********************
  // Compare
  // ********************
  // Expected word comes from the address tag
  assign expected = tg_pattern(rsp_i.addr, seed_i);
  assign mismatch = rsp_valid_i && (rsp_i.data != expected);

  // ********************
  // Result registers
  // ********************
  always_ff @(posedge c0_ddr4_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_q       <= 1'b0;
      err_flag_q   <= 1'b0;
      err_cnt_q    <= '0;
      first_addr_q <= '0;
    end else if (start_pulse_i) begin
      // New run
      done_q       <= 1'b0;
      err_flag_q   <= 1'b0;
      err_cnt_q    <= '0;
      first_addr_q <= '0;
    end else begin
      done_q <= rsp_valid_i && rsp_i.last;
      if (mismatch) begin
        err_flag_q <= 1'b1;
        // Count saturates at the top of its range
        if (err_cnt_q != '1) begin
          err_cnt_q <= err_cnt_q + 1'b1;
        end
        // Keep only the first failing address
        if (!err_flag_q) begin
          first_addr_q <= rsp_i.addr;
        end
      end
    end
  end

  assign done_o           = done_q;
  assign compare_error_o  = err_flag_q;
  assign err_count_o      = err_cnt_q;
  assign first_err_addr_o = first_addr_q;

endmodule

// File: hw/ddr4_traffic_check.sv
// Single clock domain; all inputs except start_i must be held stable during a run
`timescale 1ns/1ns

module ddr4_traffic_check (
  input  logic                   c0_ddr4_clk,
  input  logic                   arst_n_i,
  input  logic                   init_calib_complete_i,
  input  logic                   start_i,
  input  ddr4_tg_pkg::seed_t     seed_i,
  input  ddr4_tg_pkg::app_addr_t len_i,
  input  logic                   inject_en_i,
  input  ddr4_tg_pkg::app_addr_t inject_addr_i,
  output logic                   busy_o,
  output logic                   done_o,
  output logic                   compare_error_o,
  output ddr4_tg_pkg::err_cnt_t  err_count_o,
  output ddr4_tg_pkg::app_addr_t first_err_addr_o
);
  import ddr4_tg_pkg::*;

  // Command path
  logic     cmd_valid;
  app_cmd_t cmd;

  // Response path
  logic     rsp_valid;
  rd_rsp_t  rsp;

  // Run control towards the checker
  logic     start_pulse;
  seed_t    run_seed;

  tg_cmd_gen i_tg_cmd_gen (
    .c0_ddr4_clk           (c0_ddr4_clk),
    .arst_n_i              (arst_n_i),
    .init_calib_complete_i (init_calib_complete_i),
    .start_i               (start_i),
    .seed_i                (seed_i),
    .len_i                 (len_i),
    .inject_en_i           (inject_en_i),
    .inject_addr_i         (inject_addr_i),
    .cmd_valid_o           (cmd_valid),
    .cmd_o                 (cmd),
    .start_pulse_o         (start_pulse),
    .seed_o                (run_seed),
    .busy_o                (busy_o)
  );

  tg_mem_buffer i_tg_mem_buffer (
    .c0_ddr4_clk (c0_ddr4_clk),
    .arst_n_i    (arst_n_i),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp)
  );

  tg_rd_checker i_tg_rd_checker (
    .c0_ddr4_clk      (c0_ddr4_clk),
    .arst_n_i         (arst_n_i),
    .start_pulse_i    (start_pulse),
    .seed_i           (run_seed),
    .rsp_valid_i      (rsp_valid),
    .rsp_i            (rsp),
    .done_o           (done_o),
    .compare_error_o  (compare_error_o),
    .err_count_o      (err_count_o),
    .first_err_addr_o (first_err_addr_o)
  );

endmodule

// File: verification/tb_tg_model.svh
// Included inside the testbench module after the package import; predicts one run at a time
`ifndef TB_TG_MODEL_SVH
`define TB_TG_MODEL_SVH

  // Settings of one run, held stable while it is busy
  typedef struct packed {
    seed_t     seed;
    app_addr_t len;
    logic      inj_en;
    app_addr_t inj_addr;
  } run_cfg_t;

  // Results the checker reports at done
  typedef struct packed {
    logic      flag;
    err_cnt_t  count;
    app_addr_t first_addr;
  } run_res_t;

  // Upper word is seed XOR address, lower word is its complement
  function automatic app_data_t model_word(app_addr_t addr, seed_t seed);
    logic [31:0] upper;
    upper = seed ^ {24'h000000, addr};
    return {upper, ~upper};
  endfunction

  // Cycles from the accepted start to the done pulse
  function automatic int done_cycles(app_addr_t len);
    return 2 * (int'(len) + 1) + 3;
  endfunction

  // Replays the write phase into a model memory, then the read phase in order
  task automatic predict_result(input run_cfg_t cfg, output run_res_t res);
    app_data_t mem_img [MEM_WORDS];
    app_data_t word;
    int        n;
    int        a;
    n   = int'(cfg.len) + 1;
    res = '0;
    for (a = 0; a < n; a++) begin
      word = model_word(app_addr_t'(a), cfg.seed);
      // Fault insertion flips bit 0
      if (cfg.inj_en && (cfg.inj_addr == app_addr_t'(a))) begin
        word[0] = ~word[0];
      end
      mem_img[a] = word;
    end
    for (a = 0; a < n; a++) begin
      if (mem_img[a] !== model_word(app_addr_t'(a), cfg.seed)) begin
        if (!res.flag) begin
          res.first_addr = app_addr_t'(a);
        end
        res.flag  = 1'b1;
        res.count = res.count + 1'b1;
      end
    end
  endtask

`endif

// File: verification/tb_ddr4_traffic_check.sv
// Random runs from a fixed seed; the watchdog budget assumes no more than 40 runs
`timescale 1ns/1ns

module tb_ddr4_traffic_check;
  import ddr4_tg_pkg::*;

  `include "tb_tg_model.svh"

  localparam int CLK_PERIOD   = 100;
  localparam int RESET_CYCLES = 10;
  localparam int RAND_SEED    = 32'h030a32ce;
  // Longest run plus margin, and the run budget for the watchdog
  localparam int RUN_CYCLES   = 2 * MEM_WORDS + 10;
  localparam int MAX_RUNS     = 40;

  logic      c0_ddr4_clk;
  logic      arst_n_i;
  logic      init_calib_complete_i;
  logic      start_i;
  seed_t     seed_i;
  app_addr_t len_i;
  logic      inject_en_i;
  app_addr_t inject_addr_i;
  logic      busy_o;
  logic      done_o;
  logic      compare_error_o;
  err_cnt_t  err_count_o;
  app_addr_t first_err_addr_o;

  int checks;
  int errors;
  int tests_run;
  int tests_failed;

  ddr4_traffic_check i_ddr4_traffic_check (
    .c0_ddr4_clk           (c0_ddr4_clk),
    .arst_n_i              (arst_n_i),
    .init_calib_complete_i (init_calib_complete_i),
    .start_i               (start_i),
    .seed_i                (seed_i),
    .len_i                 (len_i),
    .inject_en_i           (inject_en_i),
    .inject_addr_i         (inject_addr_i),
    .busy_o                (busy_o),
    .done_o                (done_o),
    .compare_error_o       (compare_error_o),
    .err_count_o           (err_count_o),
    .first_err_addr_o      (first_err_addr_o)
  );

  initial begin
    c0_ddr4_clk = 1'b0;
    forever #(CLK_PERIOD / 2) c0_ddr4_clk = ~c0_ddr4_clk;
  end

  // ********************
  // Helpers
  // ********************
  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAILED at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: %0d errors", tests_run, name, errors - errors_before);
    end
  endtask

  // One run; stray_cycle strobes start_i again in that cycle, 0 for none
  task automatic run_traffic(input run_cfg_t cfg, input int stray_cycle);
    run_res_t exp;
    int       lat;
    logic     seen_done;
    predict_result(cfg, exp);
    @(negedge c0_ddr4_clk);
    seed_i        = cfg.seed;
    len_i         = cfg.len;
    inject_en_i   = cfg.inj_en;
    inject_addr_i = cfg.inj_addr;
    start_i       = 1'b1;
    lat           = 0;
    seen_done     = 1'b0;
    while (!seen_done && (lat < RUN_CYCLES)) begin
      @(negedge c0_ddr4_clk);
      lat++;
      start_i = (lat == stray_cycle);
      check_eq("busy_o during run", busy_o, 1);
      // Old results are gone one cycle after the start
      if (lat == 2) begin
        check_eq("compare_error_o after start", compare_error_o, 0);
        check_eq("err_count_o after start", err_count_o, 0);
      end
      seen_done = done_o;
    end
    checks++;
    assert (seen_done) else begin
      $display("Timeout at time %0t: done_o never came within %0d cycles", $time, RUN_CYCLES);
      errors++;
    end
    if (seen_done) begin
      check_eq("done_o cycle after start", lat, done_cycles(cfg.len));
      check_eq("compare_error_o", compare_error_o, exp.flag);
      check_eq("err_count_o", err_count_o, exp.count);
      if (exp.flag) begin
        check_eq("first_err_addr_o", first_err_addr_o, exp.first_addr);
      end
    end
    @(negedge c0_ddr4_clk);
    start_i = 1'b0;
    check_eq("done_o after pulse", done_o, 0);
    check_eq("busy_o after done", busy_o, 0);
    check_eq("err_count_o held", err_count_o, exp.count);
  endtask

  // ********************
  // Watchdog
  // ********************
  initial begin
    repeat (RESET_CYCLES + MAX_RUNS * RUN_CYCLES) @(posedge c0_ddr4_clk);
    $display("Watchdog expired: simulation ran past its cycle budget");
    $display("Checks failed");
    $finish;
  end

  // ********************
  // Stimulus
  // ********************
  initial begin
    run_cfg_t cfg;
    int       eb;
    int       i;
    int       stray;
    void'($urandom(RAND_SEED));
    checks                = 0;
    errors                = 0;
    tests_run             = 0;
    tests_failed          = 0;
    arst_n_i              = 1'b0;
    init_calib_complete_i = 1'b0;
    start_i               = 1'b0;
    seed_i                = '0;
    len_i                 = '0;
    inject_en_i           = 1'b0;
    inject_addr_i         = '0;
    repeat (RESET_CYCLES) @(negedge c0_ddr4_clk);
    arst_n_i = 1'b1;

    // Reset values, then a start before calibration
    eb = errors;
    @(negedge c0_ddr4_clk);
    check_eq("busy_o after reset", busy_o, 0);
    check_eq("done_o after reset", done_o, 0);
    check_eq("compare_error_o after reset", compare_error_o, 0);
    check_eq("err_count_o after reset", err_count_o, 0);
    start_i = 1'b1;
    @(negedge c0_ddr4_clk);
    start_i = 1'b0;
    repeat (5) begin
      @(negedge c0_ddr4_clk);
      check_eq("busy_o without calibration", busy_o, 0);
      check_eq("done_o without calibration", done_o, 0);
    end
    init_calib_complete_i = 1'b1;
    report_test("reset and calibration gate", eb);

    eb = errors;
    for (i = 0; i < 8; i++) begin
      cfg.seed     = $urandom;
      cfg.len      = app_addr_t'($urandom);
      cfg.inj_en   = 1'b0;
      cfg.inj_addr = app_addr_t'($urandom);
      run_traffic(cfg, 0);
    end
    report_test("clean runs", eb);

    eb = errors;
    for (i = 0; i < 8; i++) begin
      cfg.seed     = $urandom;
      cfg.len      = app_addr_t'($urandom);
      cfg.inj_en   = 1'b1;
      cfg.inj_addr = app_addr_t'($urandom % (int'(cfg.len) + 1));
      run_traffic(cfg, 0);
    end
    // Injection past the end of the window
    for (i = 0; i < 2; i++) begin
      cfg.seed     = $urandom;
      cfg.len      = app_addr_t'($urandom % 255);
      cfg.inj_en   = 1'b1;
      cfg.inj_addr = app_addr_t'(int'(cfg.len) + 1 + $urandom % (255 - int'(cfg.len)));
      run_traffic(cfg, 0);
    end
    report_test("error injection", eb);

    eb = errors;
    for (i = 0; i < 2; i++) begin
      cfg.seed     = $urandom;
      cfg.len      = app_addr_t'($urandom);
      cfg.inj_en   = i[0];
      cfg.inj_addr = app_addr_t'($urandom % (int'(cfg.len) + 1));
      stray        = 2 + $urandom % (done_cycles(cfg.len) - 1);
      run_traffic(cfg, stray);
    end
    report_test("start during busy", eb);

    eb = errors;
    for (i = 0; i < 2; i++) begin
      cfg.seed     = $urandom;
      cfg.len      = app_addr_t'($urandom);
      cfg.inj_en   = 1'b1;
      cfg.inj_addr = app_addr_t'($urandom % (int'(cfg.len) + 1));
      run_traffic(cfg, 0);
      cfg.seed     = $urandom;
      cfg.inj_en   = 1'b0;
      run_traffic(cfg, 0);
    end
    report_test("back-to-back runs", eb);

    $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: ddr4_traffic_check.f
+incdir+verification
hw/ddr4_tg_pkg.sv
hw/tg_cmd_gen.sv
hw/tg_mem_buffer.sv
hw/tg_rd_checker.sv
hw/ddr4_traffic_check.sv
verification/tb_ddr4_traffic_check.sv
